/* hw/busPkg.sv */
package busPkg;

    localparam int addrWidth = 30;  // word address, byte offset is not on the bus.
    localparam int dataWidth = 32;
    localparam int byteCount = dataWidth / 8;

    typedef logic [addrWidth-1:0] busAddr_t;
    typedef logic [dataWidth-1:0] dataWord_t;
    typedef logic [byteCount-1:0] byteEn_t;

    // One bus request, presented by the master for a single cycle.
    // The master never raises read and write together.
    typedef struct packed {
        logic      read;       // read strobe, data comes back one clock later.
        logic      write;      // write strobe, target updates at the closing edge.
        busAddr_t  addr;
        dataWord_t writeData;
        byteEn_t   byteEn;     // only used by the RAM slave.
    } busReq_t;

    // Width check for the struct, 1 + 1 + 30 + 32 + 4 bits.
    localparam int reqWidth = $bits(busReq_t);

    // Offset bits left below the slave select field.
    localparam int offsetWidth = addrWidth - 5;

    typedef logic [offsetWidth-1:0] busOffset_t;

endpackage

/* hw/mapPkg.sv */
package mapPkg;

    localparam int selBits = 5;  // top address bits that pick a slave.

    typedef logic [selBits-1:0] selVal_t;

    localparam selVal_t selRom  = 5'd0;
    localparam selVal_t selRam  = 5'd1;
    localparam selVal_t selGpio = 5'd2;

    localparam int romDepth    = 16;
    localparam int romAddrBits = $clog2(romDepth);
    localparam int ramDepth    = 64;
    localparam int ramAddrBits = $clog2(ramDepth);
    localparam int gpioWidth   = 8;
    localparam int gpioRegBits = 2;

    typedef logic [gpioWidth-1:0]   gpioPins_t;
    typedef logic [gpioRegBits-1:0] regOffset_t;

    localparam regOffset_t regOut = 2'd0;
    localparam regOffset_t regSet = 2'd1;
    localparam regOffset_t regClr = 2'd2;
    localparam regOffset_t regIn  = 2'd3;

    // Short start-up stub. It sets the stack, jumps to the loader, then spins.
    localparam busPkg::dataWord_t bootImage [0:romDepth-1] = '{
        32'h20000137, 32'h40010113, 32'h00000093, 32'h00000193,
        32'h0140006f, 32'h0000006f, 32'h08000237, 32'h00120213,
        32'h00122023, 32'h00022283, 32'hfe028ee3, 32'h00008067,
        32'h00a00513, 32'hfff50513, 32'hfe051ee3, 32'hfe1ff06f
    };

endpackage

/* hw/bootRom.sv */
`timescale 1ns/1ps

module bootRom (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic              i_Sel,
    input  busPkg::busReq_t   i_Req,
    output busPkg::dataWord_t o_ReadData
);

    busPkg::dataWord_t romMem [0:mapPkg::romDepth-1];

    busPkg::busOffset_t            offset;
    logic [mapPkg::romAddrBits-1:0] romIdx;
    logic                           inRange;

    // contents come from the boot image in the memory-map package.
    initial begin
        for (int i = 0; i < mapPkg::romDepth; i++) begin
            romMem[i] = mapPkg::bootImage[i];
        end
    end

    assign offset  = i_Req.addr[busPkg::offsetWidth-1:0];
    assign romIdx  = offset[mapPkg::romAddrBits-1:0];
    assign inRange = (offset < busPkg::busOffset_t'(mapPkg::romDepth));

    // The read port returns zero in every cycle without a selected read,
    // so the decoder never sees stale data from this slave.
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ReadData <= '0;
        end else begin
            o_ReadData <= '0;
            if (i_Sel && i_Req.read && inRange) begin
                o_ReadData <= romMem[romIdx];  // words past the image read as zero.
            end
        end
    end

endmodule

/* hw/scratchRam.sv */
`timescale 1ns/1ps

module scratchRam (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic              i_Sel,
    input  busPkg::busReq_t   i_Req,
    output busPkg::dataWord_t o_ReadData
);

    busPkg::dataWord_t ramMem [0:mapPkg::ramDepth-1];

    logic [mapPkg::ramAddrBits-1:0] ramIdx;
    logic                           wrEn;
    logic                           rdEn;

    // offsets past the end wrap, only the low bits reach the array.
    assign ramIdx = i_Req.addr[mapPkg::ramAddrBits-1:0];
    assign wrEn   = i_Sel && i_Req.write;
    assign rdEn   = i_Sel && i_Req.read;

    // Byte lanes are written independently, so a partial store keeps
    // the untouched bytes of the word.
    always_ff @(posedge i_Clk) begin
        if (wrEn) begin
            for (int b = 0; b < busPkg::byteCount; b++) begin
                if (i_Req.byteEn[b]) begin
                    ramMem[ramIdx][8*b +: 8] <= i_Req.writeData[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ReadData <= '0;
        end else begin
            o_ReadData <= '0;  // zero unless this slave is being read.
            if (rdEn) begin
                o_ReadData <= ramMem[ramIdx];
            end
        end
    end

    // a selected write with no lane enabled would be silently dropped.
    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        wrEn |-> (i_Req.byteEn != '0))
        else $error("RAM write with all byte enables low.");

endmodule

/* hw/gpioRegs.sv */
`timescale 1ns/1ps

module gpioRegs (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic              i_Sel,
    input  busPkg::busReq_t   i_Req,
    input  mapPkg::gpioPins_t i_GpioIn,
    output busPkg::dataWord_t o_ReadData,
    output mapPkg::gpioPins_t o_GpioOut
);

    mapPkg::regOffset_t regSelect;
    mapPkg::gpioPins_t  outReg;
    mapPkg::gpioPins_t  wrPins;
    mapPkg::gpioPins_t  syncMeta;
    mapPkg::gpioPins_t  syncIn;
    logic               wrEn;
    logic               rdEn;

    assign regSelect = i_Req.addr[mapPkg::gpioRegBits-1:0];
    assign wrPins    = i_Req.writeData[mapPkg::gpioWidth-1:0];
    assign wrEn      = i_Sel && i_Req.write;
    assign rdEn      = i_Sel && i_Req.read;
    assign o_GpioOut = outReg;

    // two-flop synchroniser, the pins are asynchronous to i_Clk.
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            syncMeta <= '0;
            syncIn   <= '0;
        end else begin
            syncMeta <= i_GpioIn;
            syncIn   <= syncMeta;
        end
    end

    // Set and clear let software flip single pins without a
    // read-modify-write of the output register.
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            outReg <= '0;
        end else if (wrEn) begin
            case (regSelect)
                mapPkg::regOut: outReg <= wrPins;
                mapPkg::regSet: outReg <= outReg | wrPins;
                mapPkg::regClr: outReg <= outReg & ~wrPins;
                default:        outReg <= outReg;  // the input register is read only.
            endcase
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_ReadData <= '0;
        end else begin
            o_ReadData <= '0;
            if (rdEn) begin
                if (regSelect == mapPkg::regIn) begin
                    o_ReadData <= busPkg::dataWord_t'(syncIn);
                end else begin
                    o_ReadData <= busPkg::dataWord_t'(outReg);
                end
            end
        end
    end

endmodule

/* hw/busDecoder.sv */
`timescale 1ns/1ps

module busDecoder (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  busPkg::busReq_t   i_Req,
    input  busPkg::dataWord_t i_RomData,
    input  busPkg::dataWord_t i_RamData,
    input  busPkg::dataWord_t i_GpioData,
    output logic              o_RomSel,
    output logic              o_RamSel,
    output logic              o_GpioSel,
    output busPkg::dataWord_t o_ReadData,
    output logic              o_BusErr
);

    typedef enum logic [1:0] {
        srcNone,
        srcRom,
        srcRam,
        srcGpio
    } readSrc_t;

    mapPkg::selVal_t selField;
    logic            access;
    logic            unmapped;
    logic            romWrite;
    readSrc_t        nextSrc;
    readSrc_t        readSrc;
    logic            busErr;

    assign selField  = i_Req.addr[busPkg::addrWidth-1 -: mapPkg::selBits];
    assign access    = i_Req.read | i_Req.write;
    assign o_RomSel  = access && (selField == mapPkg::selRom);
    assign o_RamSel  = access && (selField == mapPkg::selRam);
    assign o_GpioSel = access && (selField == mapPkg::selGpio);
    assign unmapped  = access && !(o_RomSel || o_RamSel || o_GpioSel);
    assign romWrite  = i_Req.write && o_RomSel;
    assign o_BusErr  = busErr;

    // only a read arms the response path, writes and idle cycles return zero.
    always_comb begin
        nextSrc = srcNone;
        if (i_Req.read) begin
            if (o_RomSel) begin
                nextSrc = srcRom;
            end else if (o_RamSel) begin
                nextSrc = srcRam;
            end else if (o_GpioSel) begin
                nextSrc = srcGpio;
            end
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            readSrc <= srcNone;
            busErr  <= 1'b0;
        end else begin
            readSrc <= nextSrc;
            busErr  <= busErr | unmapped | romWrite;  // sticky until reset.
        end
    end

    always_comb begin
        case (readSrc)
            srcRom:  o_ReadData = i_RomData;
            srcRam:  o_ReadData = i_RamData;
            srcGpio: o_ReadData = i_GpioData;
            default: o_ReadData = '0;
        endcase
    end

    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        $onehot0({o_RomSel, o_RamSel, o_GpioSel}))
        else $error("more than one slave selected.");

    assert property (@(posedge i_Clk) disable iff (!i_arstN)
        !(i_Req.read && i_Req.write))
        else $error("read and write raised in the same cycle.");

endmodule

/* hw/periphBus.sv */
`timescale 1ns/1ps

module periphBus (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  busPkg::busReq_t   i_Req,
    output busPkg::dataWord_t o_ReadData,
    output logic              o_BusErr,
    input  mapPkg::gpioPins_t i_GpioIn,
    output mapPkg::gpioPins_t o_GpioOut
);

    logic              romSel;
    logic              ramSel;
    logic              gpioSel;
    busPkg::dataWord_t romData;
    busPkg::dataWord_t ramData;
    busPkg::dataWord_t gpioData;

    busDecoder u_decoder (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Req      (i_Req),
        .i_RomData  (romData),
        .i_RamData  (ramData),
        .i_GpioData (gpioData),
        .o_RomSel   (romSel),
        .o_RamSel   (ramSel),
        .o_GpioSel  (gpioSel),
        .o_ReadData (o_ReadData),
        .o_BusErr   (o_BusErr)
    );

    // every slave sees the same request, the select picks the one that acts.
    bootRom u_rom (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Sel      (romSel),
        .i_Req      (i_Req),
        .o_ReadData (romData)
    );

    scratchRam u_ram (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Sel      (ramSel),
        .i_Req      (i_Req),
        .o_ReadData (ramData)
    );

    gpioRegs u_gpio (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_Sel      (gpioSel),
        .i_Req      (i_Req),
        .i_GpioIn   (i_GpioIn),
        .o_ReadData (gpioData),
        .o_GpioOut  (o_GpioOut)
    );

endmodule

/* sim/tbPeriphBus.sv */
`timescale 1ns/1ps

module tbPeriphBus;

    localparam int clkPeriod   = 10;
    localparam int maxCycles   = 20000;  // whole run, well above the stimulus length.

    logic              clk;
    logic              arstN;
    busPkg::busReq_t   req;
    busPkg::dataWord_t readData;
    logic              busErr;
    mapPkg::gpioPins_t gpioIn;
    mapPkg::gpioPins_t gpioOut;

    int     checkCount;
    int     mismatchCount;
    int     otherErrCount;
    integer seed;

    periphBus u_dut (
        .i_Clk      (clk),
        .i_arstN    (arstN),
        .i_Req      (req),
        .o_ReadData (readData),
        .o_BusErr   (busErr),
        .i_GpioIn   (gpioIn),
        .o_GpioOut  (gpioOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        repeat (maxCycles) @(posedge clk);
        $display("Simulation ran out of cycles before the stimulus file was finished.");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkData(input busPkg::dataWord_t got, input busPkg::dataWord_t exp,
                             input string what);
        checkCount++;
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at time %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkErr(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkPins(input mapPkg::gpioPins_t got, input mapPkg::gpioPins_t exp,
                             input string what);
        checkCount++;
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at time %0t: %s are %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        arstN <= 1'b0;
        req   <= '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkData(readData, '0, "read data after reset");
        checkErr(busErr, 1'b0, "bus error flag after reset");
        checkPins(gpioOut, '0, "GPIO outputs after reset");
    endtask

    task automatic busWrite(input busPkg::busAddr_t addr, input busPkg::dataWord_t data,
                            input busPkg::byteEn_t be);
        busPkg::busReq_t r;
        r           = '0;
        r.write     = 1'b1;
        r.addr      = addr;
        r.writeData = data;
        r.byteEn    = be;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
    endtask

    // data is sampled mid-cycle, one clock after the read cycle.
    task automatic busRead(input busPkg::busAddr_t addr, output busPkg::dataWord_t data);
        busPkg::busReq_t r;
        r      = '0;
        r.read = 1'b1;
        r.addr = addr;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        data = readData;
    endtask

    task automatic romSweep(input busPkg::busAddr_t base, input int count);
        busPkg::busAddr_t  addr;
        busPkg::dataWord_t got;
        busPkg::dataWord_t exp;
        int                offset;
        for (int i = 0; i < count; i++) begin
            addr   = base + busPkg::busAddr_t'(i);
            offset = int'(addr[busPkg::addrWidth-mapPkg::selBits-1:0]);
            exp    = '0;  // words past the image read as zero.
            if (offset < mapPkg::romDepth) begin
                exp = mapPkg::bootImage[offset];
            end
            busRead(addr, got);
            checkData(got, exp, $sformatf("boot ROM offset %0d", offset));
        end
    endtask

    task automatic randomFill(input busPkg::busAddr_t base, input int count);
        busPkg::dataWord_t model [$];
        busPkg::dataWord_t word;
        busPkg::dataWord_t got;
        for (int i = 0; i < count; i++) begin
            word = $random(seed);
            model.push_back(word);
            busWrite(base + busPkg::busAddr_t'(i), word, '1);
        end
        for (int i = 0; i < count; i++) begin
            busRead(base + busPkg::busAddr_t'(i), got);
            checkData(got, model[i], $sformatf("random RAM word %0d", i));
        end
    endtask

    task automatic waitPins(input busPkg::busAddr_t addr, input mapPkg::gpioPins_t pins,
                            input busPkg::dataWord_t exp);
        busPkg::dataWord_t got;
        int                waited;
        @(posedge clk);
        gpioIn <= pins;
        waited = 0;
        while (waited < 3) begin  // two synchroniser edges plus one spare.
            @(posedge clk);
            waited++;
        end
        busRead(addr, got);
        checkData(got, exp, "GPIO input register");
    endtask

    task automatic runOp(input string op, input busPkg::busAddr_t addr,
                         input busPkg::dataWord_t data, input busPkg::byteEn_t be,
                         input busPkg::dataWord_t expVal);
        busPkg::dataWord_t got;
        case (op)
            "T": applyReset();
            "W": busWrite(addr, data, be);
            "R": begin
                busRead(addr, got);
                checkData(got, expVal, $sformatf("read of %h", addr));
            end
            "B": romSweep(addr, int'(data));
            "X": randomFill(addr, int'(data));
            "P": waitPins(addr, data[mapPkg::gpioWidth-1:0], expVal);
            "G": begin
                @(negedge clk);
                checkPins(gpioOut, data[mapPkg::gpioWidth-1:0], "GPIO outputs");
            end
            "E": begin
                @(negedge clk);
                checkErr(busErr, data[0], "bus error flag");
            end
            default: begin
                otherErrCount++;
                $display("Unknown operation %s in the stimulus file.", op);
            end
        endcase
    endtask

    initial begin
        int                fd;
        int                fields;
        int                lineNo;
        string             line;
        string             op;
        busPkg::busAddr_t  addr;
        busPkg::dataWord_t data;
        busPkg::byteEn_t   be;
        busPkg::dataWord_t expVal;

        arstN         = 1'b0;
        req           = '0;
        gpioIn        = '0;
        seed          = 32'h62b7778e;
        checkCount    = 0;
        mismatchCount = 0;
        otherErrCount = 0;
        applyReset();

        fd = $fopen("sim/busStim.txt", "r");
        if (fd == 0) begin
            otherErrCount++;
            $display("Could not open the stimulus file sim/busStim.txt.");
        end else begin
            lineNo = 0;
            while (!$feof(fd)) begin
                line   = "";
                fields = $fgets(line, fd);
                lineNo++;
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %h %h %h %h", op, addr, data, be, expVal);
                if (fields != 5) begin
                    otherErrCount++;
                    $display("Stimulus line %0d does not hold five fields.", lineNo);
                    continue;
                end
                runOp(op, addr, data, be, expVal);
            end
            $fclose(fd);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checkCount, mismatchCount, otherErrCount);
        if (mismatchCount == 0 && otherErrCount == 0 && checkCount > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim/busStim.txt */
# columns: op, word address, data, byte enables, expected value (all hex)
# ops: T reset, W write, R read and check, B ROM sweep of data words, X random RAM
# fill of data words, P drive pins and poll regIn, G check GPIO outputs, E check error flag
T 00000000 00000000 0 00000000
E 00000000 00000000 0 00000000
B 00000000 00000014 0 00000000
E 00000000 00000000 0 00000000
# RAM byte lanes, then an offset past the end that wraps to word 1
W 02000000 11223344 f 00000000
R 02000000 00000000 0 11223344
W 02000000 aabbccdd 5 00000000
R 02000000 00000000 0 11bb33dd
W 02000000 55667788 8 00000000
R 02000000 00000000 0 55bb33dd
W 02000001 00000000 f 00000000
W 02000001 cafef00d 6 00000000
R 02000001 00000000 0 00fef000
W 02000041 12345678 3 00000000
R 02000001 00000000 0 00fe5678
R 02000041 00000000 0 00fe5678
X 02000010 00000010 0 00000000
# GPIO output register with set and clear, then the input pins
W 04000000 000000a5 f 00000000
G 00000000 000000a5 0 00000000
R 04000000 00000000 0 000000a5
W 04000001 0000000a f 00000000
G 00000000 000000af 0 00000000
R 04000001 00000000 0 000000af
W 04000002 00000081 f 00000000
G 00000000 0000002e 0 00000000
R 04000002 00000000 0 0000002e
W 04000000 ffffff3c f 00000000
G 00000000 0000003c 0 00000000
P 04000003 0000005a 0 0000005a
P 04000003 000000c3 0 000000c3
P 04000003 00000000 0 00000000
E 00000000 00000000 0 00000000
# unmapped read, then a ROM write after a fresh reset
R 06000000 00000000 0 00000000
E 00000000 00000001 0 00000000
R 02000000 00000000 0 55bb33dd
T 00000000 00000000 0 00000000
W 00000003 deadbeef f 00000000
E 00000000 00000001 0 00000000
B 00000000 00000010 0 00000000
E 00000000 00000001 0 00000000
T 00000000 00000000 0 00000000
E 00000000 00000000 0 00000000

/* sim.f */
hw/busPkg.sv
hw/mapPkg.sv
hw/bootRom.sv
hw/scratchRam.sv
hw/gpioRegs.sv
hw/busDecoder.sv
hw/periphBus.sv
sim/tbPeriphBus.sv

/* Makefile */
SRC := $(wildcard hw/*.sv sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/VtbPeriphBus: $(SRC) sim.f
	verilator --binary --timing --assert -f sim.f --top-module tbPeriphBus -o VtbPeriphBus

run: obj_dir/VtbPeriphBus
	./obj_dir/VtbPeriphBus | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
